// File: common/spi_capture_pkg.sv
// SPI capture shared definitions
// Holds the channel count, the word and register widths, the register map,
// the frame configuration struct and the per-channel state encoding used by
// the multi-channel SPI slave receiver
`default_nettype none

package spi_capture_pkg;

    // Number of MOSI and slave select lanes that share one SCLK
    localparam int N_CHANNELS = 3;

    // Width of one captured word
    localparam int WORD_WIDTH = 32;

    // Number of implemented bits in the control register
    localparam int CTRL_WIDTH = 4;

    // One captured word, right aligned and MSB first
    typedef logic [WORD_WIDTH-1:0] sample_t;

    // Word length or bit position; a stored length L stands for L+1 bits
    typedef logic [4:0] bit_count_t;

    // Register bus word address and data
    typedef logic [1:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Counter of words captured across all channels
    typedef logic [15:0] word_count_t;

    // Register map
    localparam reg_addr_t REG_CONTROL    = 2'd0;
    localparam reg_addr_t REG_LENGTH     = 2'd1;
    localparam reg_addr_t REG_WORD_COUNT = 2'd2;

    // Control register bit positions
    localparam int CTRL_CPOL_BIT   = 0;
    localparam int CTRL_CPHA_BIT   = 1;
    localparam int CTRL_SS_POL_BIT = 2;
    localparam int CTRL_ENABLE_BIT = 3;

    // Frame format shared by every channel
    typedef struct packed {
        logic       enable;
        // Idle level of SCLK
        logic       clock_polarity;
        // Zero latches on the leading edge, one on the trailing edge
        logic       latching_edge;
        // Active level of slave select
        logic       ss_polarity;
        bit_count_t length;
    } spi_cfg_t;

    // Channel frame tracker state
    typedef enum logic {
        CH_IDLE,
        CH_SHIFT
    } ch_state_t;

endpackage

`default_nettype wire

// File: hw/spi_capture_regs.sv
// SPI capture register block
// Holds the frame format that steers every receiver channel and a saturating
// counter of the words captured on all channels together
// Plain strobe bus with combinational read data
`timescale 1ns/10ps
`default_nettype none

module spi_capture_regs (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  reg_write,
    input  spi_capture_pkg::reg_addr_t            reg_addr,
    input  spi_capture_pkg::reg_data_t            reg_wdata,
    output spi_capture_pkg::reg_data_t            reg_rdata,
    input  logic [spi_capture_pkg::N_CHANNELS-1:0] data_valid,
    output spi_capture_pkg::spi_cfg_t             cfg
);

    import spi_capture_pkg::*;

    // Enough bits to hold the number of channels that finish in one cycle
    localparam int VALID_COUNT_WIDTH = $clog2(N_CHANNELS + 1);

    logic [CTRL_WIDTH-1:0]         control_q;
    bit_count_t                    length_q;
    word_count_t                   word_count_q;
    logic [VALID_COUNT_WIDTH-1:0]  valid_count;
    logic [$bits(word_count_t):0]  count_sum;

    // Control and length registers, cleared so the receiver starts disabled
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            control_q <= '0;
            length_q  <= '0;
        end else if (reg_write) begin
            if (reg_addr == REG_CONTROL) begin
                control_q <= reg_wdata[CTRL_WIDTH-1:0];
            end
            if (reg_addr == REG_LENGTH) begin
                length_q <= reg_wdata[$bits(bit_count_t)-1:0];
            end
        end
    end

    // Number of channels that delivered a word this cycle
    always_comb begin
        valid_count = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            valid_count = valid_count + VALID_COUNT_WIDTH'(data_valid[i]);
        end
    end

    // One extra bit catches the overflow that triggers saturation
    assign count_sum = {1'b0, word_count_q} + ($bits(count_sum))'(valid_count);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            word_count_q <= '0;
        end else if (reg_write && reg_addr == REG_WORD_COUNT) begin
            // Any write to the counter address clears it
            word_count_q <= '0;
        end else if (count_sum[$bits(word_count_t)]) begin
            word_count_q <= '1;
        end else begin
            word_count_q <= count_sum[$bits(word_count_t)-1:0];
        end
    end

    // Read data follows the address, unused addresses read zero
    always_comb begin
        case (reg_addr)
            REG_CONTROL:    reg_rdata = reg_data_t'(control_q);
            REG_LENGTH:     reg_rdata = reg_data_t'(length_q);
            REG_WORD_COUNT: reg_rdata = reg_data_t'(word_count_q);
            default:        reg_rdata = '0;
        endcase
    end

    // Frame format handed to every channel
    assign cfg.enable         = control_q[CTRL_ENABLE_BIT];
    assign cfg.clock_polarity = control_q[CTRL_CPOL_BIT];
    assign cfg.latching_edge  = control_q[CTRL_CPHA_BIT];
    assign cfg.ss_polarity    = control_q[CTRL_SS_POL_BIT];
    assign cfg.length         = length_q;

    // A write to an unknown address would silently miss every register
    a_write_addr_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        reg_write |-> !$isunknown(reg_addr)
    ) else $error("Register write with unknown address");

endmodule

`default_nettype wire

// File: hw/spi_capture_top.sv
// Multi-channel SPI slave capture
// Ties the register block, the shared input synchronizer and one receiver per
// channel together, and registers each finished word with a valid strobe
`timescale 1ns/10ps
`default_nettype none

module spi_capture_top (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic                                   reg_write,
    input  spi_capture_pkg::reg_addr_t             reg_addr,
    input  spi_capture_pkg::reg_data_t             reg_wdata,
    output spi_capture_pkg::reg_data_t             reg_rdata,
    input  logic                                   sclk,
    input  logic [spi_capture_pkg::N_CHANNELS-1:0] ss,
    input  logic [spi_capture_pkg::N_CHANNELS-1:0] mosi,
    output spi_capture_pkg::sample_t               data_out [spi_capture_pkg::N_CHANNELS-1:0],
    output logic [spi_capture_pkg::N_CHANNELS-1:0] data_valid
);

    import spi_capture_pkg::*;

    spi_cfg_t              cfg;
    logic                  sclk_rise;
    logic                  sclk_fall;
    logic [N_CHANNELS-1:0] ss_sync;
    logic [N_CHANNELS-1:0] mosi_sync;
    sample_t               ch_word [N_CHANNELS-1:0];
    logic [N_CHANNELS-1:0] ch_done;

    // Configuration and word counter, fed back from the registered strobes
    spi_capture_regs u_regs (
        .clock      (clock),
        .rst_n      (rst_n),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .data_valid (data_valid),
        .cfg        (cfg)
    );

    // One SCLK path serves every channel
    spi_bus_sync u_sync (
        .clock     (clock),
        .rst_n     (rst_n),
        .sclk      (sclk),
        .ss        (ss),
        .mosi      (mosi),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .ss_sync   (ss_sync),
        .mosi_sync (mosi_sync)
    );

    for (genvar i = 0; i < N_CHANNELS; i++) begin : gen_channel
        spi_shift_channel u_channel (
            .clock     (clock),
            .rst_n     (rst_n),
            .cfg       (cfg),
            .sclk_rise (sclk_rise),
            .sclk_fall (sclk_fall),
            .ss_sync   (ss_sync[i]),
            .mosi_sync (mosi_sync[i]),
            .word      (ch_word[i]),
            .word_done (ch_done[i])
        );
    end

    // Output stage; a new word simply overwrites the previous one
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= '0;
            for (int i = 0; i < N_CHANNELS; i++) begin
                data_out[i] <= '0;
            end
        end else begin
            data_valid <= ch_done;
            for (int i = 0; i < N_CHANNELS; i++) begin
                if (ch_done[i]) begin
                    data_out[i] <= ch_word[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the SPI capture testbench with Verilator and runs it
# The result is decided by the pass line in sim.log
rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal -f spi_capture.f \
    --top-module spi_capture_tb -o spi_capture_sim > build.log 2>&1 &&
{ ./obj_dir/spi_capture_sim > sim.log 2>&1 || true; } &&
grep -qx "No errors" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: spi_capture.f
+incdir+tests
common/spi_capture_pkg.sv
hw/spi_capture_regs.sv
spi_receiver/spi_bus_sync.sv
spi_receiver/spi_shift_channel.sv
hw/spi_capture_top.sv
tests/spi_capture_tb.sv

// File: spi_receiver/spi_bus_sync.sv
// SPI input synchronizer
// Brings the shared SCLK and the per-channel slave select and MOSI lines into
// the system clock domain and turns SCLK transitions into edge pulses
`timescale 1ns/10ps
`default_nettype none

module spi_bus_sync (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic                                   sclk,
    input  logic [spi_capture_pkg::N_CHANNELS-1:0] ss,
    input  logic [spi_capture_pkg::N_CHANNELS-1:0] mosi,
    output logic                                   sclk_rise,
    output logic                                   sclk_fall,
    output logic [spi_capture_pkg::N_CHANNELS-1:0] ss_sync,
    output logic [spi_capture_pkg::N_CHANNELS-1:0] mosi_sync
);

    import spi_capture_pkg::*;

    // Two synchronizing stages plus one history stage for edge detection
    logic [2:0]            sclk_q;
    logic [N_CHANNELS-1:0] ss_meta;
    logic [N_CHANNELS-1:0] ss_q;
    logic [N_CHANNELS-1:0] mosi_meta;
    logic [N_CHANNELS-1:0] mosi_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q    <= '0;
            ss_meta   <= '0;
            ss_q      <= '0;
            mosi_meta <= '0;
            mosi_q    <= '0;
        end else begin
            sclk_q    <= {sclk_q[1:0], sclk};
            ss_meta   <= ss;
            ss_q      <= ss_meta;
            mosi_meta <= mosi;
            mosi_q    <= mosi_meta;
        end
    end

    // Edge pulses line up with the synchronized MOSI sample
    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];

    assign ss_sync   = ss_q;
    assign mosi_sync = mosi_q;

endmodule

`default_nettype wire

// File: spi_receiver/spi_shift_channel.sv
// SPI receiver channel
// Tracks one slave select frame, counts bits on the selected SCLK edge and
// shifts MOSI in MSB first, emitting each finished word with a done pulse
// Several words may follow each other inside one frame
`timescale 1ns/10ps
`default_nettype none

module spi_shift_channel (
    input  logic                        clock,
    input  logic                        rst_n,
    input  spi_capture_pkg::spi_cfg_t   cfg,
    input  logic                        sclk_rise,
    input  logic                        sclk_fall,
    input  logic                        ss_sync,
    input  logic                        mosi_sync,
    output spi_capture_pkg::sample_t    word,
    output logic                        word_done
);

    import spi_capture_pkg::*;

    ch_state_t  state_q;
    bit_count_t bit_count_q;
    sample_t    shift_q;
    sample_t    word_q;
    logic       word_done_q;
    logic       active;
    logic       latch_pulse;
    logic       last_bit;
    sample_t    shift_next;

    // Channel only listens while enabled and selected
    assign active = cfg.enable && (ss_sync == cfg.ss_polarity);

    // The leading edge is the rise when SCLK idles low and the fall when it
    // idles high; the trailing edge is the opposite one, so the choice
    // collapses to the XOR of polarity and edge select
    assign latch_pulse = (cfg.clock_polarity ^ cfg.latching_edge) ? sclk_fall : sclk_rise;

    // Bit count equal to the programmed length marks the final bit of a word
    assign last_bit = (bit_count_q == cfg.length);

    // New bits enter at the LSB so the first bit ends up as the MSB
    assign shift_next = {shift_q[WORD_WIDTH-2:0], mosi_sync};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= CH_IDLE;
            bit_count_q <= '0;
            shift_q     <= '0;
            word_done_q <= 1'b0;
        end else begin
            word_done_q <= 1'b0;
            case (state_q)
                CH_IDLE: begin
                    bit_count_q <= '0;
                    shift_q     <= '0;
                    if (active) begin
                        state_q <= CH_SHIFT;
                    end
                end
                CH_SHIFT: begin
                    if (!active) begin
                        // Slave select released, any partial word is dropped
                        state_q     <= CH_IDLE;
                        bit_count_q <= '0;
                        shift_q     <= '0;
                    end else if (latch_pulse) begin
                        if (last_bit) begin
                            // Word complete; restart for the next word in the frame
                            word_done_q <= 1'b1;
                            bit_count_q <= '0;
                            shift_q     <= '0;
                        end else begin
                            bit_count_q <= bit_count_q + 1'b1;
                            shift_q     <= shift_next;
                        end
                    end
                end
                default: begin
                    state_q <= CH_IDLE;
                end
            endcase
        end
    end

    // Finished word is held here while the shifter restarts
    always_ff @(posedge clock) begin
        if (state_q == CH_SHIFT && active && latch_pulse && last_bit) begin
            word_q <= shift_next;
        end
    end

    assign word      = word_q;
    assign word_done = word_done_q;

    // The synchronizer can only report one SCLK transition per cycle
    a_single_edge: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(sclk_rise && sclk_fall)
    ) else $error("SCLK rise and fall pulses overlap");

    // A completed word is announced for exactly one cycle
    a_done_pulse: assert property (
        @(posedge clock) disable iff (!rst_n)
        word_done |=> !word_done
    ) else $error("Word done held longer than one cycle");

endmodule

`default_nettype wire

// File: tests/spi_master_bfm.svh
// SPI master and register bus master models
// Clocks one word per channel in parallel on the shared SCLK with the current
// polarity, latching edge and slave select level, and accesses the registers
`ifndef SPI_MASTER_BFM_SVH
`define SPI_MASTER_BFM_SVH

// Half of the 8-cycle SCLK period
localparam int HALF_PERIOD = 4;

task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge clock);
    reg_write = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clock);
    reg_write = 1'b0;
endtask

// Read data is combinational and is taken a full cycle after the address
task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    @(negedge clock);
    reg_addr = addr;
    @(negedge clock);
    data = reg_rdata;
endtask

// The receiver stays disabled while SCLK and slave select move to new idle levels
task automatic configure(input logic cpol, input logic cpha, input logic ss_pol,
                         input int nbits);
    reg_data_t ctrl;
    ctrl = '0;
    ctrl[CTRL_CPOL_BIT]   = cpol;
    ctrl[CTRL_CPHA_BIT]   = cpha;
    ctrl[CTRL_SS_POL_BIT] = ss_pol;
    ctrl[CTRL_ENABLE_BIT] = 1'b1;
    write_reg(REG_CONTROL, '0);
    sclk_idle = cpol;
    trailing  = cpha;
    ss_active = ss_pol;
    sclk      = cpol;
    ss        = {N_CHANNELS{~ss_pol}};
    repeat (2 * HALF_PERIOD) @(negedge clock);
    write_reg(REG_LENGTH, reg_data_t'(nbits - 1));
    write_reg(REG_CONTROL, ctrl);
endtask

// Bit k of word w on every channel
function automatic logic [N_CHANNELS-1:0] mosi_bits(input int w, input int k);
    logic [N_CHANNELS-1:0] bits;
    for (int ch = 0; ch < N_CHANNELS; ch++) begin
        bits[ch] = tx_words[ch][w][k];
    end
    return bits;
endfunction

// Clocks nclocks bits of tx_words, nbits per word and MSB first
// Fewer clocks than a whole word leave that word unfinished
task automatic spi_frame(input int nbits, input int nclocks);
    int w;
    int k;
    @(negedge clock);
    ss = {N_CHANNELS{ss_active}};
    repeat (HALF_PERIOD) @(negedge clock);
    for (int b = 0; b < nclocks; b++) begin
        w = b / nbits;
        k = nbits - 1 - (b % nbits);
        // MOSI always changes half a period before the latching edge
        if (!trailing) mosi = mosi_bits(w, k);
        repeat (HALF_PERIOD) @(negedge clock);
        sclk = ~sclk_idle;
        if (trailing) mosi = mosi_bits(w, k);
        repeat (HALF_PERIOD) @(negedge clock);
        sclk = sclk_idle;
    end
    // Slave select is held long enough for the last edge to pass the synchronizer
    repeat (HALF_PERIOD) @(negedge clock);
    ss = {N_CHANNELS{~ss_active}};
    repeat (2 * HALF_PERIOD) @(negedge clock);
endtask

`endif

// File: tests/spi_capture_tb.sv
// Testbench for the multi-channel SPI capture block
// Runs directed tests through the register bus and an SPI master model and
// compares every captured word with the word that was sent
`timescale 1ns/10ps
`default_nettype none

module spi_capture_tb;

    import spi_capture_pkg::*;

    // The tests take about 2500 cycles in total, well inside this limit
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MAX_WORDS      = 3;

    logic                  clock;
    logic                  rst_n;
    logic                  reg_write;
    reg_addr_t             reg_addr;
    reg_data_t             reg_wdata;
    reg_data_t             reg_rdata;
    logic                  sclk;
    logic [N_CHANNELS-1:0] ss;
    logic [N_CHANNELS-1:0] mosi;
    sample_t               data_out [N_CHANNELS-1:0];
    logic [N_CHANNELS-1:0] data_valid;

    // Frame format the SPI master model currently uses
    logic sclk_idle;
    logic trailing;
    logic ss_active;

    sample_t     tx_words [N_CHANNELS][MAX_WORDS];
    sample_t     rx_words [N_CHANNELS][$];
    word_count_t expected_total;
    int          cycle_count = 0;

    spi_capture_top u_dut (
        .clock      (clock),
        .rst_n      (rst_n),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .sclk       (sclk),
        .ss         (ss),
        .mosi       (mosi),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    `include "spi_master_bfm.svh"

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Captured words are collected on the falling edge where the strobes are stable
    always @(negedge clock) begin
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            if (data_valid[ch]) rx_words[ch].push_back(data_out[ch]);
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic check_sample(input string test, input sample_t expected,
                                input sample_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", test, expected, actual);
            $display("Errors found");
            $fatal(1, "Captured word mismatch");
        end
    endtask

    task automatic check_count(input string test, input word_count_t expected,
                               input word_count_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", test, expected, actual);
            $display("Errors found");
            $fatal(1, "Word count mismatch");
        end
    endtask

    task automatic check_flag(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", test, expected, actual);
            $display("Errors found");
            $fatal(1, "Flag mismatch");
        end
    endtask

    task automatic check_reg(input string test, input reg_data_t expected,
                             input reg_data_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", test, expected, actual);
            $display("Errors found");
            $fatal(1, "Register read mismatch");
        end
    endtask

    // Words are right aligned with zeros above the programmed length
    function automatic sample_t word_mask(input int nbits);
        return (nbits >= WORD_WIDTH) ? '1 : ((sample_t'(1) << nbits) - sample_t'(1));
    endfunction

    // Fresh random words for every slot and empty receive queues
    task automatic load_words(input int nbits);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            for (int w = 0; w < MAX_WORDS; w++) begin
                tx_words[ch][w] = $urandom() & word_mask(nbits);
            end
            rx_words[ch].delete();
        end
    endtask

    // Waits until every channel has delivered its words and checks them in order
    task automatic check_words(input string test, input int nwords);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            while (rx_words[ch].size() < nwords) @(posedge clock);
        end
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            check_count(test, word_count_t'(nwords), word_count_t'(rx_words[ch].size()));
            for (int w = 0; w < nwords; w++) begin
                check_sample(test, tx_words[ch][w], rx_words[ch][w]);
            end
        end
        expected_total = expected_total + word_count_t'(N_CHANNELS * nwords);
    endtask

    task automatic test_reset_disabled();
        reg_data_t rdata;
        check_flag("reset_disabled", 1'b0, |data_valid);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            check_sample("reset_disabled", '0, data_out[ch]);
        end
        // Address 3 is unused and reads zero as well
        for (int a = 0; a < 4; a++) begin
            read_reg(reg_addr_t'(a), rdata);
            check_reg("reset_disabled", '0, rdata);
        end
        load_words(16);
        spi_frame(16, 16);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            check_flag("reset_disabled", 1'b0, rx_words[ch].size() != 0);
        end
    endtask

    task automatic test_basic_capture();
        reg_data_t rdata;
        reg_data_t ctrl_expected;
        ctrl_expected                  = '0;
        ctrl_expected[CTRL_ENABLE_BIT] = 1'b1;
        configure(1'b0, 1'b0, 1'b0, 16);
        // Control holds only the enable bit here and the length field holds bits minus one
        read_reg(REG_CONTROL, rdata);
        check_reg("basic_capture", ctrl_expected, rdata);
        read_reg(REG_LENGTH, rdata);
        check_reg("basic_capture", reg_data_t'(15), rdata);
        load_words(16);
        spi_frame(16, 16);
        check_words("basic_capture", 1);
    endtask

    // Bits 0 to 2 of the mode select polarity, latching edge and slave select level
    task automatic test_modes();
        for (int mode = 0; mode < 8; mode++) begin
            configure(mode[0], mode[1], mode[2], 8);
            load_words(8);
            spi_frame(8, 8);
            check_words($sformatf("modes_%0d", mode), 1);
        end
    endtask

    task automatic test_length_back_to_back();
        int lengths [3] = '{1, 7, 32};
        foreach (lengths[i]) begin
            configure(1'b1, 1'b0, 1'b1, lengths[i]);
            load_words(lengths[i]);
            spi_frame(lengths[i], MAX_WORDS * lengths[i]);
            check_words($sformatf("length_%0d", lengths[i]), MAX_WORDS);
        end
    endtask

    task automatic test_abort();
        configure(1'b0, 1'b1, 1'b0, 12);
        load_words(12);
        spi_frame(12, 5);
        // No word may arrive, so the test only waits out a quiet period
        repeat (4 * HALF_PERIOD) @(negedge clock);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            check_count("abort", '0, word_count_t'(rx_words[ch].size()));
        end
        load_words(12);
        spi_frame(12, 12);
        check_words("abort", 1);
    endtask

    task automatic test_word_counter();
        reg_data_t rdata;
        read_reg(REG_WORD_COUNT, rdata);
        check_count("word_counter", expected_total, word_count_t'(rdata));
        write_reg(REG_WORD_COUNT, '0);
        read_reg(REG_WORD_COUNT, rdata);
        check_count("word_counter", '0, word_count_t'(rdata));
    endtask

    initial begin
        void'($urandom(92007));
        rst_n          = 1'b0;
        reg_write      = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        sclk           = 1'b0;
        ss             = '1;
        mosi           = '0;
        sclk_idle      = 1'b0;
        trailing       = 1'b0;
        ss_active      = 1'b0;
        expected_total = '0;
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        test_reset_disabled();
        test_basic_capture();
        test_modes();
        test_length_back_to_back();
        test_abort();
        test_word_counter();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
